//--- src/qla_pkg.sv
// qla shared definitions
// address map, register offsets, data widths and the safety constants
// used by the axis control core and its testbench

`default_nettype none

package qla_pkg;

    // ------------------------------------------------------------------------
    // bus types
    // ------------------------------------------------------------------------
    localparam int CUR_W = 16;                 // dac and adc code width

    typedef logic [15:0]      addr_t;          // register address
    typedef logic [31:0]      data_t;          // register data word
    typedef logic [CUR_W-1:0] cur_t;           // offset-binary current

    // ------------------------------------------------------------------------
    // address map
    // addr[15:12] space | addr[7:4] channel | addr[3:0] offset
    // ------------------------------------------------------------------------
    localparam int SPACE_LSB = 12;
    localparam int CHAN_LSB  = 4;              // channel 0 is the board
    localparam int CHAN_W    = 4;

    typedef enum logic [3:0] {
        space_main     = 4'h0,                 // only space with live data
        space_hub      = 4'h1,
        space_prom     = 4'h2,
        space_prom_qla = 4'h3
    } addr_space_e;

    typedef enum logic [3:0] {
        off_status = 4'h0,                     // board status and control
        off_dout   = 4'h1                      // board digital outputs
    } reg_offset_e;

    // axis channels reuse offset 1 for the current command
    localparam reg_offset_e off_dac_ctrl = off_dout;

    // ------------------------------------------------------------------------
    // status word layout
    // ------------------------------------------------------------------------
    localparam int STAT_AMP_EN_LSB   = 0;      // bits 3..0
    localparam int STAT_FAULT_LSB    = 4;      // bits 7..4
    localparam int STAT_PWR_EN_BIT   = 8;
    localparam int WR_FAULT_CLR_BIT  = 9;      // write only
    localparam int STAT_BOARD_ID_LSB = 24;     // bits 27..24
    localparam int BOARD_ID_W        = 4;

    // ------------------------------------------------------------------------
    // safety
    // ------------------------------------------------------------------------
    localparam cur_t MID_SCALE     = 16'h8000; // zero current code
    localparam cur_t SAFETY_MARGIN = 16'h0200; // slack over 2x command

endpackage

`default_nettype wire

//--- src/reg_read_mux.sv
// register read-data mux
// picks board or axis read data by address space and channel,
// everything outside the main space reads as zero

`default_nettype none

module reg_read_mux #(
    parameter int NUM_AXES = 4
) (
    input  wire qla_pkg::addr_t reg_raddr,
    input  wire qla_pkg::data_t board_rdata,   // channel 0
    input  wire qla_pkg::data_t axis_rdata,    // channels 1..NUM_AXES
    output      qla_pkg::data_t reg_rdata
);

    import qla_pkg::*;

    addr_space_e       rd_space;
    logic [CHAN_W-1:0] rd_chan;
    logic              is_axis;

    // address fields
    assign rd_space = addr_space_e'(reg_raddr[SPACE_LSB +: 4]);
    assign rd_chan  = reg_raddr[CHAN_LSB +: CHAN_W];

    // axis channels start at 1
    assign is_axis = (rd_chan != '0) && (rd_chan <= CHAN_W'(NUM_AXES));

    // ------------------------------------------------------------------------
    // combinational select, same cycle as reg_raddr
    // ------------------------------------------------------------------------
    always_comb begin
        reg_rdata = '0;                        // hub and prom spaces dropped
        if (rd_space == space_main) begin
            if (rd_chan == '0) begin
                reg_rdata = board_rdata;
            end else if (is_axis) begin
                reg_rdata = axis_rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/board_regs.sv
// board register block, channel 0
// holds amp enables, power enable and digital outputs, builds the
// live status word and issues the fault clear pulse

`default_nettype none

module board_regs #(
    parameter int NUM_AXES = 4
) (
    input  wire logic                sysclk,
    input  wire logic                rst_n,
    input  wire logic                reg_wen,
    input  wire qla_pkg::addr_t      reg_waddr,
    input  wire qla_pkg::data_t      reg_wdata,
    input  wire qla_pkg::addr_t      reg_raddr,
    input  wire logic [3:0]          board_id,
    input  wire logic [NUM_AXES-1:0] fault,        // from safety check
    output      qla_pkg::data_t      board_rdata,
    output      logic [NUM_AXES-1:0] amp_disable,
    output      logic                pwr_enable,
    output      logic [3:0]          dout,
    output      logic                fault_clear   // one-cycle pulse
);

    import qla_pkg::*;

    logic [NUM_AXES-1:0] amp_en;       // software amp enables
    logic                wr_hit;       // write to main space, channel 0
    reg_offset_e         wr_off;
    reg_offset_e         rd_off;
    data_t               status_word;

    // ------------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------------
    assign wr_hit = reg_wen
                 && (addr_space_e'(reg_waddr[SPACE_LSB +: 4]) == space_main)
                 && (reg_waddr[CHAN_LSB +: CHAN_W] == '0);
    assign wr_off = reg_offset_e'(reg_waddr[3:0]);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_en      <= '0;                 // all amps off
            pwr_enable  <= 1'b0;
            dout        <= '0;
            fault_clear <= 1'b0;
        end else begin
            fault_clear <= 1'b0;               // default, pulse only
            if (wr_hit) begin
                case (wr_off)
                    off_status: begin
                        amp_en      <= reg_wdata[STAT_AMP_EN_LSB +: NUM_AXES];
                        pwr_enable  <= reg_wdata[STAT_PWR_EN_BIT];
                        fault_clear <= reg_wdata[WR_FAULT_CLR_BIT];
                    end
                    off_dout: begin
                        dout <= reg_wdata[3:0];
                    end
                    default: begin
                        // other board offsets have no storage
                    end
                endcase
            end
        end
    end

    // an axis runs only when enabled and not faulted
    assign amp_disable = ~amp_en | fault;

    // ------------------------------------------------------------------------
    // readback
    // ------------------------------------------------------------------------
    assign rd_off = reg_offset_e'(reg_raddr[3:0]);

    always_comb begin
        status_word = '0;
        status_word[STAT_AMP_EN_LSB +: NUM_AXES] = amp_en;
        status_word[STAT_FAULT_LSB +: NUM_AXES]  = fault;    // live faults
        status_word[STAT_PWR_EN_BIT]             = pwr_enable;
        status_word[STAT_BOARD_ID_LSB +: BOARD_ID_W] = board_id;
    end

    always_comb begin
        case (rd_off)
            off_status: board_rdata = status_word;
            off_dout:   board_rdata = {28'd0, dout};
            default:    board_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/dac_cmd_regs.sv
// motor current command registers
// one 16-bit offset-binary command per axis, written through the
// register bus and read back at the dac control offset

`default_nettype none

module dac_cmd_regs #(
    parameter int NUM_AXES = 4
) (
    input  wire logic                         sysclk,
    input  wire logic                         rst_n,
    input  wire logic                         reg_wen,
    input  wire qla_pkg::addr_t               reg_waddr,
    input  wire qla_pkg::data_t               reg_wdata,
    input  wire qla_pkg::addr_t               reg_raddr,
    output      qla_pkg::data_t               axis_rdata,
    output      qla_pkg::cur_t [NUM_AXES-1:0] cur_cmd
);

    import qla_pkg::*;

    logic [CHAN_W-1:0] wr_chan;
    logic [CHAN_W-1:0] rd_chan;
    logic              wr_hit;        // main space, dac offset

    assign wr_chan = reg_waddr[CHAN_LSB +: CHAN_W];
    assign rd_chan = reg_raddr[CHAN_LSB +: CHAN_W];

    assign wr_hit = reg_wen
                 && (addr_space_e'(reg_waddr[SPACE_LSB +: 4]) == space_main)
                 && (reg_offset_e'(reg_waddr[3:0]) == off_dac_ctrl);

    // ------------------------------------------------------------------------
    // command storage, channel n drives axis n-1
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                cur_cmd[i] <= MID_SCALE;       // zero current
            end
        end else if (wr_hit) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (wr_chan == CHAN_W'(i + 1)) begin
                    cur_cmd[i] <= reg_wdata[CUR_W-1:0];
                end
            end
        end
    end

    // readback, zero-extended
    always_comb begin
        axis_rdata = '0;
        if (reg_offset_e'(reg_raddr[3:0]) == off_dac_ctrl) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (rd_chan == CHAN_W'(i + 1)) begin
                    axis_rdata = {16'd0, cur_cmd[i]};
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/safety_check.sv
// over-current safety check
// per axis, latches a fault when feedback runs far past the command
// for SAFETY_COUNT consecutive cycles, held until fault clear

`default_nettype none

module safety_check #(
    parameter int NUM_AXES     = 4,
    parameter int SAFETY_COUNT = 8
) (
    input  wire logic                         sysclk,
    input  wire logic                         rst_n,
    input  wire qla_pkg::cur_t [NUM_AXES-1:0] cur_fb,
    input  wire qla_pkg::cur_t [NUM_AXES-1:0] cur_cmd,
    input  wire logic                         fault_clear,
    output      logic [NUM_AXES-1:0]          fault
);

    import qla_pkg::*;

    localparam int                CNT_W   = $clog2(SAFETY_COUNT + 1);
    localparam logic [CNT_W-1:0]  CNT_MAX = CNT_W'(SAFETY_COUNT);

    for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
        cur_t             fb_dev;      // |fb - mid|
        cur_t             cmd_dev;     // |cmd - mid|
        logic [CUR_W+1:0] limit;       // 2 * cmd_dev + margin
        logic             over;
        logic [CNT_W-1:0] cnt;         // consecutive over cycles
        logic             fault_q;

        // bit 15 set means at or above mid scale
        assign fb_dev  = cur_fb[a][CUR_W-1] ? cur_fb[a] - MID_SCALE
                                            : MID_SCALE - cur_fb[a];
        assign cmd_dev = cur_cmd[a][CUR_W-1] ? cur_cmd[a] - MID_SCALE
                                             : MID_SCALE - cur_cmd[a];

        assign limit = {1'b0, cmd_dev, 1'b0} + {2'b00, SAFETY_MARGIN};
        assign over  = {2'b00, fb_dev} > limit;

        // --------------------------------------------------------------------
        // counter and latched fault
        // --------------------------------------------------------------------
        always_ff @(posedge sysclk) begin
            if (!rst_n) begin
                cnt     <= '0;
                fault_q <= 1'b0;
            end else if (fault_clear) begin   // wins over a new latch
                cnt     <= '0;
                fault_q <= 1'b0;
            end else begin
                if (!over) begin
                    cnt <= '0;                 // run broken
                end else if (cnt != CNT_MAX) begin
                    cnt <= cnt + 1'b1;         // saturates at the limit
                end
                if (cnt == CNT_MAX) begin
                    fault_q <= 1'b1;
                end
            end
        end

        assign fault[a] = fault_q;
    end

endmodule

`default_nettype wire

//--- src/qla_top.sv
// qla axis control core
// ties the register bus to the board registers, the current command
// registers, the over-current checks and the read-data mux

`default_nettype none

module qla_top #(
    parameter int NUM_AXES     = 4,
    parameter int SAFETY_COUNT = 8
) (
    input  wire logic                              sysclk,
    input  wire logic                              rst_n,
    input  wire logic                              reg_wen,     // one-cycle write strobe
    input  wire qla_pkg::addr_t                    reg_waddr,
    input  wire qla_pkg::data_t                    reg_wdata,
    input  wire qla_pkg::addr_t                    reg_raddr,
    input  wire logic [3:0]                        board_id,    // rotary switch
    input  wire qla_pkg::cur_t [NUM_AXES-1:0]      cur_fb,      // measured current
    output      qla_pkg::data_t                    reg_rdata,
    output      qla_pkg::cur_t [NUM_AXES-1:0]      cur_cmd,     // to the dacs
    output      logic [NUM_AXES-1:0]               amp_disable,
    output      logic                              pwr_enable,
    output      logic [3:0]                        dout
);

    import qla_pkg::*;

    data_t               board_rdata;    // channel 0 word
    data_t               axis_rdata;     // addressed axis word
    logic [NUM_AXES-1:0] fault;          // latched over-current
    logic                fault_clear;    // one-cycle pulse

    // ------------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------------
    reg_read_mux #(.NUM_AXES(NUM_AXES)) u_reg_read_mux (
        .reg_raddr   (reg_raddr),
        .board_rdata (board_rdata),
        .axis_rdata  (axis_rdata),
        .reg_rdata   (reg_rdata)
    );

    // board registers, channel 0
    board_regs #(.NUM_AXES(NUM_AXES)) u_board_regs (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .board_id    (board_id),
        .fault       (fault),
        .board_rdata (board_rdata),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable),
        .dout        (dout),
        .fault_clear (fault_clear)
    );

    // per-axis current commands
    dac_cmd_regs #(.NUM_AXES(NUM_AXES)) u_dac_cmd_regs (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_raddr  (reg_raddr),
        .axis_rdata (axis_rdata),
        .cur_cmd    (cur_cmd)
    );

    // ------------------------------------------------------------------------
    // over-current checks, feedback vs command
    // ------------------------------------------------------------------------
    safety_check #(
        .NUM_AXES     (NUM_AXES),
        .SAFETY_COUNT (SAFETY_COUNT)
    ) u_safety_check (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .fault_clear (fault_clear),
        .fault       (fault)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// testbench clock source
// free-running clock, starts low, toggles every half period

`default_nettype none

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;    // 50 percent duty

endmodule

`default_nettype wire

//--- dv/qla_assert.sv
// fault and fault clear assertions
// bound into safety_check and board_regs, both of which see the
// fault vector and the fault clear pulse

`default_nettype none

module qla_assert #(
    parameter int NUM_AXES = 4
) (
    input wire logic                sysclk,
    input wire logic                rst_n,
    input wire logic [NUM_AXES-1:0] fault,
    input wire logic                fault_clear
);

    // faults come out of reset cleared
    a_fault_reset: assert property (@(posedge sysclk) !rst_n |=> (fault == '0))
        else $error("fault vector not zero after reset");

    // a latched fault only drops after a fault clear pulse
    a_fault_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        (|($past(fault) & ~fault)) |-> $past(fault_clear))
        else $error("fault fell without fault clear");

    // fault clear is a single-cycle pulse
    a_clear_pulse: assert property (@(posedge sysclk) disable iff (!rst_n)
        fault_clear |=> !fault_clear)
        else $error("fault clear held longer than one cycle");

endmodule

bind safety_check qla_assert #(.NUM_AXES(NUM_AXES)) u_qla_assert (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .fault       (fault),
    .fault_clear (fault_clear)
);

bind board_regs qla_assert #(.NUM_AXES(NUM_AXES)) u_qla_assert (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .fault       (fault),
    .fault_clear (fault_clear)
);

`default_nettype wire

//--- dv/tb_qla_top.sv
// testbench for the qla axis control core
// random register traffic and feedback currents from a fixed seed,
// checked every cycle against a cycle-level reference model

`default_nettype none

module tb_qla_top;

    import qla_pkg::*;

    localparam int NUM_AXES     = 4;
    localparam int SAFETY_COUNT = 8;
    localparam int PERIOD       = 20;
    localparam int RESET_CYC    = 10;
    localparam int NUM_TXN      = 4000;   // random cycles
    localparam int DIRECTED_CYC = 200;    // upper bound, directed part
    localparam int CYC_PER_TXN  = 2;      // slack per transaction
    localparam longint TIMEOUT  =
        longint'(NUM_TXN + DIRECTED_CYC) * CYC_PER_TXN * PERIOD + RESET_CYC * PERIOD;

    // fb modes per axis
    localparam int FB_RUN  = 0;           // random near/far runs
    localparam int FB_NEAR = 1;
    localparam int FB_FAR  = 2;

    logic                   sysclk;
    logic                   rst_n;
    logic                   reg_wen;
    addr_t                  reg_waddr;
    data_t                  reg_wdata;
    addr_t                  reg_raddr;
    logic [3:0]             board_id;
    cur_t [NUM_AXES-1:0]    cur_fb;
    data_t                  reg_rdata;
    cur_t [NUM_AXES-1:0]    cur_cmd;
    logic [NUM_AXES-1:0]    amp_disable;
    logic                   pwr_enable;
    logic [3:0]             dout;

    // pending drive values, applied at the next falling edge
    logic       p_rst_n;
    logic       p_wen;
    addr_t      p_waddr;
    data_t      p_wdata;
    addr_t      p_raddr;
    logic [3:0] p_board_id;
    int         fb_mode [NUM_AXES];
    int         run_left [NUM_AXES];
    logic       run_far [NUM_AXES];

    // reference model state
    logic [NUM_AXES-1:0] m_amp_en;
    logic [NUM_AXES-1:0] m_fault;
    logic                m_pwr;
    logic                m_fclr;
    logic [3:0]          m_dout;
    int                  m_cnt [NUM_AXES];
    cur_t                m_cmd [NUM_AXES];

    int   seed = 35;
    logic checks_on;
    logic last_clr;                       // previous write set fault clear
    logic at_fall;                        // sequence already sits on a falling edge

    tb_clock #(.PERIOD(PERIOD)) u_tb_clock (.clk(sysclk));

    qla_top #(
        .NUM_AXES     (NUM_AXES),
        .SAFETY_COUNT (SAFETY_COUNT)
    ) u_qla_top (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .board_id    (board_id),
        .cur_fb      (cur_fb),
        .reg_rdata   (reg_rdata),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable),
        .dout        (dout)
    );

    // ------------------------------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic fail_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_cur(input string name, input cur_t got, input cur_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bits(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // model helpers
    // ------------------------------------------------------------------------
    function automatic int urand(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // distance from the zero-current code
    function automatic int dev_of(input cur_t v);
        if (v >= MID_SCALE) begin
            return int'(v) - int'(MID_SCALE);
        end
        return int'(MID_SCALE) - int'(v);
    endfunction

    function automatic int limit_of(input cur_t cmd);
        return 2 * dev_of(cmd) + int'(SAFETY_MARGIN);
    endfunction

    function automatic data_t status_exp();
        data_t d;
        d = '0;
        d[STAT_AMP_EN_LSB +: NUM_AXES]       = m_amp_en;
        d[STAT_FAULT_LSB +: NUM_AXES]        = m_fault;
        d[STAT_PWR_EN_BIT]                   = m_pwr;
        d[STAT_BOARD_ID_LSB +: BOARD_ID_W]   = board_id;
        return d;
    endfunction

    // expected read data from the address map
    function automatic data_t exp_read(input addr_t a);
        int chan;
        chan = int'(a[CHAN_LSB +: CHAN_W]);
        if (a[15:12] != space_main) begin
            return '0;                         // hub and prom spaces
        end
        if (chan == 0) begin
            if (a[3:0] == off_status) begin
                return status_exp();
            end
            if (a[3:0] == off_dout) begin
                return {28'd0, m_dout};
            end
            return '0;
        end
        if (chan <= NUM_AXES && a[3:0] == off_dac_ctrl) begin
            return {16'd0, m_cmd[chan - 1]};
        end
        return '0;
    endfunction

    task automatic model_reset();
        m_amp_en = '0;
        m_fault  = '0;
        m_pwr    = 1'b0;
        m_fclr   = 1'b0;
        m_dout   = '0;
        for (int a = 0; a < NUM_AXES; a++) begin
            m_cnt[a] = 0;
            m_cmd[a] = MID_SCALE;
        end
    endtask

    // one rising edge, all updates from pre-edge values
    task automatic model_tick();
        logic clr_now;
        logic over;
        int   chan;
        if (!rst_n) begin
            model_reset();
            return;
        end
        clr_now = m_fclr;
        m_fclr  = 1'b0;
        for (int a = 0; a < NUM_AXES; a++) begin
            over = dev_of(cur_fb[a]) > limit_of(m_cmd[a]);
            if (clr_now) begin
                m_cnt[a]   = 0;
                m_fault[a] = 1'b0;
            end else begin
                if (m_cnt[a] == SAFETY_COUNT) begin
                    m_fault[a] = 1'b1;
                end
                if (!over) begin
                    m_cnt[a] = 0;
                end else if (m_cnt[a] < SAFETY_COUNT) begin
                    m_cnt[a] = m_cnt[a] + 1;
                end
            end
        end
        chan = int'(reg_waddr[CHAN_LSB +: CHAN_W]);
        if (reg_wen && reg_waddr[15:12] == space_main) begin
            if (chan == 0 && reg_waddr[3:0] == off_status) begin
                m_amp_en = reg_wdata[STAT_AMP_EN_LSB +: NUM_AXES];
                m_pwr    = reg_wdata[STAT_PWR_EN_BIT];
                m_fclr   = reg_wdata[WR_FAULT_CLR_BIT];
            end else if (chan == 0 && reg_waddr[3:0] == off_dout) begin
                m_dout = reg_wdata[3:0];
            end else if (chan >= 1 && chan <= NUM_AXES
                         && reg_waddr[3:0] == off_dac_ctrl) begin
                m_cmd[chan - 1] = reg_wdata[CUR_W-1:0];
            end
        end
    endtask

    task automatic check_all();
        logic [NUM_AXES-1:0] exp_dis;
        exp_dis = ~m_amp_en | m_fault;         // off unless enabled and healthy
        check_data("reg_rdata", reg_rdata, exp_read(reg_raddr));
        for (int a = 0; a < NUM_AXES; a++) begin
            check_cur($sformatf("cur_cmd[%0d]", a), cur_cmd[a], m_cmd[a]);
        end
        check_bits("amp_disable", 8'(amp_disable), 8'(exp_dis));
        check_bits("pwr_enable", 8'(pwr_enable), 8'(m_pwr));
        check_bits("dout", 8'(dout), 8'(m_dout));
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    function automatic cur_t fb_value(input int a, input logic far);
        int lim;
        int d;
        lim = limit_of(m_cmd[a]);
        if (far) begin
            d = lim + 1 + urand(16'h0800);
        end else begin
            d = urand(lim + 1);
        end
        if (d > 16'h7fff) begin
            d = 16'h7fff;
        end
        if (urand(2) == 1) begin
            return cur_t'(int'(MID_SCALE) + d);
        end
        return cur_t'(int'(MID_SCALE) - d);
    endfunction

    // falling edge: check, drive, then follow the rising edge in the model
    task automatic step();
        logic stat_hit;
        if (!at_fall) begin
            @(negedge sysclk);
        end
        at_fall = 1'b0;
        if (checks_on) begin
            check_all();
        end
        rst_n     = p_rst_n;
        reg_waddr = p_waddr;
        reg_wdata = p_wdata;
        reg_raddr = p_raddr;
        reg_wen   = p_wen;
        board_id  = p_board_id;
        stat_hit  = reg_waddr[15:12] == space_main && reg_waddr[7:0] == 8'h00;
        // fault clear pulses stay one cycle apart
        if (reg_wen && stat_hit && last_clr) begin
            reg_wdata[WR_FAULT_CLR_BIT] = 1'b0;
        end
        last_clr = reg_wen && stat_hit && reg_wdata[WR_FAULT_CLR_BIT];
        for (int a = 0; a < NUM_AXES; a++) begin
            if (fb_mode[a] == FB_RUN) begin
                if (run_left[a] == 0) begin
                    run_far[a]  = urand(3) == 0;
                    run_left[a] = 1 + urand(2 * SAFETY_COUNT + 4);
                end
                run_left[a] = run_left[a] - 1;
                cur_fb[a]   = fb_value(a, run_far[a]);
            end else begin
                cur_fb[a] = fb_value(a, fb_mode[a] == FB_FAR);
            end
        end
        p_wen = 1'b0;                          // writes are one-shot
        @(posedge sysclk);
        model_tick();
    endtask

    // park on a falling edge for a directed check, the next step starts here
    task automatic wait_fall();
        @(negedge sysclk);
        at_fall = 1'b1;
    endtask

    task automatic gen_random();
        int kind;
        int cmd_off;
        p_wen   = urand(2) == 1;
        p_wdata = data_t'($random(seed));
        kind    = urand(8);
        if (kind < 3) begin
            p_waddr = {8'h00, 4'(1 + urand(NUM_AXES)), 4'(off_dac_ctrl)};
            cmd_off = urand(16'h2000) - 16'h1000;   // keep near mid scale
            p_wdata[15:0] = cur_t'(int'(MID_SCALE) + cmd_off);
        end else if (kind < 5) begin
            p_waddr = 16'h0000;
            p_wdata[WR_FAULT_CLR_BIT] = urand(4) == 0;
        end else if (kind == 5) begin
            p_waddr = 16'h0001;
        end else begin
            p_waddr = addr_t'($random(seed));
        end
        case (urand(4))
            0: p_raddr = 16'h0000;
            1: p_raddr = 16'h0001;
            2: p_raddr = {8'h00, 4'(1 + urand(NUM_AXES)), 4'(off_dac_ctrl)};
            default: p_raddr = addr_t'($random(seed));
        endcase
        if (urand(16) == 0) begin
            p_board_id = 4'(urand(16));        // live switch change
        end
    endtask

    task automatic set_fb_mode(input int mode);
        for (int a = 0; a < NUM_AXES; a++) begin
            fb_mode[a] = mode;
        end
    endtask

    task automatic write_reg(input addr_t a, input data_t d);
        p_wen   = 1'b1;
        p_waddr = a;
        p_wdata = d;
        step();
    endtask

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------
    initial begin
        #(TIMEOUT);
        $display("TIMEOUT: the tests did not finish within %0d time units", TIMEOUT);
        fail_run();
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_raddr  = '0;
        board_id   = 4'h5;
        cur_fb     = {NUM_AXES{MID_SCALE}};
        p_rst_n    = 1'b0;
        p_wen      = 1'b0;
        p_waddr    = '0;
        p_wdata    = '0;
        p_raddr    = '0;
        p_board_id = 4'h5;
        checks_on  = 1'b0;
        last_clr   = 1'b0;
        at_fall    = 1'b0;
        for (int a = 0; a < NUM_AXES; a++) begin
            run_left[a] = 0;
            run_far[a]  = 1'b0;
        end
        set_fb_mode(FB_NEAR);
        model_reset();

        repeat (RESET_CYC) step();
        checks_on = 1'b1;
        p_rst_n   = 1'b1;
        step();

        // reset values, literal expectations
        wait_fall();
        check_bits("amp_disable after reset", 8'(amp_disable), 8'({NUM_AXES{1'b1}}));
        check_bits("pwr_enable after reset", 8'(pwr_enable), 8'h00);
        check_bits("dout after reset", 8'(dout), 8'h00);
        check_data("status after reset", reg_rdata, {4'h0, board_id, 24'h0});
        for (int a = 1; a <= NUM_AXES; a++) begin
            p_raddr = {8'h00, 4'(a), 4'(off_dac_ctrl)};
            step();
            wait_fall();
            check_data("axis readback after reset", reg_rdata, 32'h0000_8000);
        end

        // dropped spaces read zero
        for (int i = 0; i < 16; i++) begin
            p_raddr = {4'(1 + urand(3)), 12'(urand(4096))};
            step();
            wait_fall();
            check_data("hub or prom read", reg_rdata, '0);
        end

        // axis 0 fault: a broken run must not latch
        write_reg(16'h0000, 32'h0000_010f);    // amps and power on
        p_raddr    = 16'h0000;
        fb_mode[0] = FB_FAR;
        repeat (SAFETY_COUNT - 1) step();
        fb_mode[0] = FB_NEAR;
        step();
        fb_mode[0] = FB_FAR;
        repeat (SAFETY_COUNT) step();
        wait_fall();
        check_bits("fault before latch", 8'(reg_rdata[STAT_FAULT_LSB]), 8'h00);
        step();
        wait_fall();
        check_bits("fault after latch", 8'(reg_rdata[STAT_FAULT_LSB]), 8'h01);
        check_bits("amp_disable[0] on fault", 8'(amp_disable[0]), 8'h01);

        // fault clear, then counting starts again
        fb_mode[0] = FB_NEAR;
        write_reg(16'h0000, 32'h0000_030f);
        step();
        wait_fall();
        check_bits("fault after clear", 8'(reg_rdata[STAT_FAULT_LSB]), 8'h00);
        fb_mode[0] = FB_FAR;
        repeat (SAFETY_COUNT + 2) step();

        // random traffic
        set_fb_mode(FB_RUN);
        for (int t = 0; t < NUM_TXN; t++) begin
            gen_random();
            step();
        end
        @(negedge sysclk);
        check_all();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/qla_pkg.sv
src/reg_read_mux.sv
src/board_regs.sv
src/dac_cmd_regs.sv
src/safety_check.sv
src/qla_top.sv
dv/tb_clock.sv
dv/qla_assert.sv
dv/tb_qla_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_qla_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
